// File: csr_unit.f
source/csr_pkg.sv
source/csr_mode_regs.sv
source/csr_int_ctrl.sv
source/csr_timer.sv
source/csr_scratch_regs.sv
source/csr_read_mux.sv
source/csr_unit.sv
verification/tb_csr_unit.sv

// File: Bender.yml
package:
  name: csr_unit

sources:
  - files:
      - source/csr_pkg.sv
      - source/csr_mode_regs.sv
      - source/csr_int_ctrl.sv
      - source/csr_timer.sv
      - source/csr_scratch_regs.sv
      - source/csr_read_mux.sv
      - source/csr_unit.sv
  - target: test
    files:
      - verification/tb_csr_unit.sv

// File: verification/tb_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 5;
    localparam int TEST_CYCLES     = 3000;
    localparam int WATCHDOG_CYCLES = 3100;
    localparam int N_KEPT          = 14;

    logic clk;
    logic resetn;
    csr_pkg::csr_wr_t wr;
    csr_pkg::exc_evt_t evt;
    logic [csr_pkg::CSR_ADDR_W-1:0] raddr;
    logic [31:0] rdata;
    logic has_int;
    logic flush;
    logic [31:0] flush_pc;

    logic [31:0] lfsr_state;
    logic [csr_pkg::CSR_ADDR_W-1:0] addr_table [N_KEPT];

    // Reference model state
    logic [1:0] m_plv;
    logic m_ie;
    logic m_da;
    logic m_pg;
    logic [1:0] m_datf;
    logic [1:0] m_datm;
    logic [1:0] m_pplv;
    logic m_pie;
    logic [5:0] m_ecode;
    logic [8:0] m_esubcode;
    logic [31:0] m_era;
    logic [31:0] m_eentry;
    logic [12:0] m_lie;
    logic [1:0] m_sw;
    logic m_tis;
    logic m_en;
    logic m_per;
    logic [29:0] m_initval;
    logic [31:0] m_tid;
    logic [31:0] m_cnt;
    logic [31:0] m_save [4];

    csr_unit i_dut (
        .clk      (clk),
        .resetn   (resetn),
        .wr       (wr),
        .evt      (evt),
        .raddr    (raddr),
        .rdata    (rdata),
        .has_int  (has_int),
        .flush    (flush),
        .flush_pc (flush_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the test sequence completed");
        $display("*** TEST FAILED ***");
        $fatal(1, "Timeout");
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Mostly kept registers and sometimes anywhere in the space
    task automatic draw_addr(output logic [csr_pkg::CSR_ADDR_W-1:0] a);
        logic [31:0] r;
        draw_bits(4, r);
        if (r[3:0] < N_KEPT) begin
            a = addr_table[r[3:0]];
        end else begin
            draw_bits(csr_pkg::CSR_ADDR_W, r);
            a = r[csr_pkg::CSR_ADDR_W-1:0];
        end
    endtask

    function automatic logic [31:0] masked_update(input logic [31:0] old_word,
                                                  input csr_pkg::csr_wr_t w);
        return (old_word & ~w.wmask) | (w.wdata & w.wmask);
    endfunction

    function automatic logic addr_hit(input csr_pkg::csr_wr_t w,
                                      input logic [csr_pkg::CSR_ADDR_W-1:0] a);
        return w.we && (w.waddr == a);
    endfunction

    function automatic logic [31:0] expected_read(input logic [csr_pkg::CSR_ADDR_W-1:0] a);
        case (a)
            csr_pkg::ADDR_CRMD:   return {23'b0, m_datm, m_datf, m_pg, m_da, m_ie, m_plv};
            csr_pkg::ADDR_PRMD:   return {29'b0, m_pie, m_pplv};
            csr_pkg::ADDR_ECFG:   return {19'b0, m_lie};
            csr_pkg::ADDR_ESTAT:  return {1'b0, m_esubcode, m_ecode, 4'b0, m_tis, 9'b0, m_sw};
            csr_pkg::ADDR_ERA:    return m_era;
            csr_pkg::ADDR_EENTRY: return m_eentry;
            csr_pkg::ADDR_SAVE0:  return m_save[0];
            csr_pkg::ADDR_SAVE1:  return m_save[1];
            csr_pkg::ADDR_SAVE2:  return m_save[2];
            csr_pkg::ADDR_SAVE3:  return m_save[3];
            csr_pkg::ADDR_TID:    return m_tid;
            csr_pkg::ADDR_TCFG:   return {m_initval, m_per, m_en};
            csr_pkg::ADDR_TVAL:   return m_cnt;
            default:              return '0;
        endcase
    endfunction

    task automatic model_reset();
        {m_plv, m_ie, m_pg, m_datf, m_datm, m_pplv, m_pie} = '0;
        m_da = 1'b1;
        {m_ecode, m_esubcode, m_era, m_eentry, m_lie, m_sw, m_tis} = '0;
        {m_en, m_per, m_initval, m_tid} = '0;
        m_cnt = '1;
        for (int i = 0; i < 4; i++) begin
            m_save[i] = '0;
        end
    endtask

    // One clock edge of the model with all merges taken from the old state
    task automatic model_step(input csr_pkg::csr_wr_t w, input csr_pkg::exc_evt_t e);
        logic [31:0] crmd_n;
        logic [31:0] prmd_n;
        logic [31:0] ecfg_n;
        logic [31:0] estat_n;
        logic [31:0] tcfg_n;
        logic fire;
        logic clr;
        crmd_n  = masked_update(expected_read(csr_pkg::ADDR_CRMD), w);
        prmd_n  = masked_update(expected_read(csr_pkg::ADDR_PRMD), w);
        ecfg_n  = masked_update(expected_read(csr_pkg::ADDR_ECFG), w);
        estat_n = masked_update(expected_read(csr_pkg::ADDR_ESTAT), w);
        tcfg_n  = masked_update(expected_read(csr_pkg::ADDR_TCFG), w);
        fire    = m_en && (m_cnt == '0);
        clr     = addr_hit(w, csr_pkg::ADDR_TICLR) && w.wmask[0] && w.wdata[0];
        if (e.exc) begin
            m_pplv     = m_plv;
            m_pie      = m_ie;
            m_plv      = '0;
            m_ie       = 1'b0;
            m_era      = e.pc;
            m_ecode    = e.ecode;
            m_esubcode = e.esubcode;
        end else begin
            if (e.ertn) begin
                m_plv = m_pplv;
                m_ie  = m_pie;
            end else if (addr_hit(w, csr_pkg::ADDR_CRMD)) begin
                m_plv = crmd_n[1:0];
                m_ie  = crmd_n[2];
            end
            if (addr_hit(w, csr_pkg::ADDR_PRMD)) begin
                m_pplv = prmd_n[1:0];
                m_pie  = prmd_n[2];
            end
            if (addr_hit(w, csr_pkg::ADDR_ERA)) begin
                m_era = masked_update(m_era, w);
            end
        end
        if (addr_hit(w, csr_pkg::ADDR_CRMD)) begin
            m_da   = crmd_n[3];
            m_pg   = crmd_n[4];
            m_datf = crmd_n[6:5];
            m_datm = crmd_n[8:7];
        end
        if (addr_hit(w, csr_pkg::ADDR_EENTRY)) begin
            m_eentry = masked_update(m_eentry, w) & 32'hffff_ffc0;
        end
        if (addr_hit(w, csr_pkg::ADDR_ECFG)) begin
            m_lie = ecfg_n[12:0];
        end
        if (addr_hit(w, csr_pkg::ADDR_ESTAT)) begin
            m_sw = estat_n[1:0];
        end
        if (fire) begin
            m_tis = 1'b1;
        end else if (clr) begin
            m_tis = 1'b0;
        end
        if (addr_hit(w, csr_pkg::ADDR_TCFG) && tcfg_n[0]) begin
            m_cnt = {tcfg_n[31:2], 2'b00};
        end else if (m_en && m_cnt != '1) begin
            if (m_cnt == '0 && m_per) begin
                m_cnt = {m_initval, 2'b00};
            end else begin
                m_cnt = m_cnt - 32'd1;
            end
        end
        if (addr_hit(w, csr_pkg::ADDR_TCFG)) begin
            m_en      = tcfg_n[0];
            m_per     = tcfg_n[1];
            m_initval = tcfg_n[31:2];
        end
        if (addr_hit(w, csr_pkg::ADDR_TID)) begin
            m_tid = masked_update(m_tid, w);
        end
        if (w.we && w.waddr >= csr_pkg::ADDR_SAVE0 && w.waddr <= csr_pkg::ADDR_SAVE3) begin
            m_save[w.waddr[1:0]] = masked_update(m_save[w.waddr[1:0]], w);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at first mismatch");
    endtask

    task automatic check_outputs();
        logic [31:0] exp_rdata;
        logic exp_flush;
        logic [31:0] exp_pc;
        logic exp_int;
        exp_rdata = expected_read(raddr);
        exp_flush = evt.exc | evt.ertn | evt.refetch;
        exp_pc    = evt.exc ? m_eentry : (evt.refetch ? evt.pc + 32'd4 : m_era);
        exp_int   = (|({m_tis, 9'b0, m_sw} & m_lie[11:0])) && m_ie;
        assert (rdata === exp_rdata) else report_mismatch("rdata", exp_rdata, rdata);
        assert (flush === exp_flush) else report_mismatch("flush", exp_flush, flush);
        assert (has_int === exp_int) else report_mismatch("has_int", exp_int, has_int);
        assert (flush_pc === exp_pc) else report_mismatch("flush_pc", exp_pc, flush_pc);
    endtask

    task automatic draw_stimulus(output csr_pkg::csr_wr_t w, output csr_pkg::exc_evt_t e,
                                 output logic [csr_pkg::CSR_ADDR_W-1:0] a);
        logic [31:0] r;
        draw_bits(1, r);
        w.we = r[0];
        draw_addr(w.waddr);
        draw_bits(2, r);
        if (r[1:0] == 2'b00) begin
            w.wmask = '1;
        end else begin
            draw_bits(32, w.wmask);
        end
        draw_bits(32, w.wdata);
        // Short timer periods so the count reaches zero often
        if (w.waddr == csr_pkg::ADDR_TCFG) begin
            w.wdata[31:6] = '0;
        end
        e = '0;
        draw_bits(5, r);
        e.exc     = (r[4:0] == 5'd0);
        e.ertn    = (r[4:0] == 5'd1);
        e.refetch = (r[4:0] == 5'd2);
        draw_bits(6, r);
        e.ecode = r[5:0];
        draw_bits(9, r);
        e.esubcode = r[8:0];
        draw_bits(32, e.pc);
        draw_addr(a);
    endtask

    // Model sees the inputs of the closing cycle and outputs are checked mid-cycle
    task automatic run_cycle(input csr_pkg::csr_wr_t w, input csr_pkg::exc_evt_t e,
                             input logic [csr_pkg::CSR_ADDR_W-1:0] a);
        @(posedge clk);
        model_step(wr, evt);
        wr    <= w;
        evt   <= e;
        raddr <= a;
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        csr_pkg::csr_wr_t w;
        csr_pkg::exc_evt_t e;
        logic [csr_pkg::CSR_ADDR_W-1:0] a;
        addr_table = '{csr_pkg::ADDR_CRMD, csr_pkg::ADDR_PRMD, csr_pkg::ADDR_ECFG,
                       csr_pkg::ADDR_ESTAT, csr_pkg::ADDR_ERA, csr_pkg::ADDR_EENTRY,
                       csr_pkg::ADDR_SAVE0, csr_pkg::ADDR_SAVE1, csr_pkg::ADDR_SAVE2,
                       csr_pkg::ADDR_SAVE3, csr_pkg::ADDR_TID, csr_pkg::ADDR_TCFG,
                       csr_pkg::ADDR_TVAL, csr_pkg::ADDR_TICLR};
        lfsr_state = 32'hdbc5;
        resetn = 1'b0;
        wr     = '0;
        evt    = '0;
        raddr  = '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
        // Reset values of every register and of an unmapped address
        for (int i = 0; i <= N_KEPT; i++) begin
            a = (i < N_KEPT) ? addr_table[i] : 14'h3fff;
            run_cycle('0, '0, a);
        end
        repeat (TEST_CYCLES) begin
            draw_stimulus(w, e, a);
            run_cycle(w, e, a);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  wire                           clk,
    input  wire                           resetn,
    input  wire csr_pkg::csr_wr_t         wr,
    input  wire csr_pkg::exc_evt_t        evt,
    input  wire [csr_pkg::CSR_ADDR_W-1:0] raddr,
    output logic [csr_pkg::XLEN-1:0]      rdata,
    output logic                          has_int,
    output logic                          flush,
    output logic [csr_pkg::XLEN-1:0]      flush_pc
);

    csr_pkg::mode_view_t  mode_view;
    csr_pkg::int_view_t   int_view;
    csr_pkg::timer_view_t timer_view;
    csr_pkg::save_view_t  save_view;
    logic crmd_ie;
    logic timer_fire;
    logic tmr_clear;

    csr_mode_regs i_mode_regs (
        .clk      (clk),
        .resetn   (resetn),
        .wr       (wr),
        .evt      (evt),
        .view     (mode_view),
        .crmd_ie  (crmd_ie),
        .flush    (flush),
        .flush_pc (flush_pc)
    );

    csr_int_ctrl i_int_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .wr         (wr),
        .crmd_ie    (crmd_ie),
        .timer_fire (timer_fire),
        .tmr_clear  (tmr_clear),
        .view       (int_view),
        .has_int    (has_int)
    );

    csr_timer i_timer (
        .clk        (clk),
        .resetn     (resetn),
        .wr         (wr),
        .view       (timer_view),
        .timer_fire (timer_fire),
        .tmr_clear  (tmr_clear)
    );

    csr_scratch_regs i_scratch_regs (
        .clk    (clk),
        .resetn (resetn),
        .wr     (wr),
        .view   (save_view)
    );

    csr_read_mux i_read_mux (
        .raddr (raddr),
        .mode  (mode_view),
        .intr  (int_view),
        .timer (timer_view),
        .save  (save_view),
        .rdata (rdata)
    );

endmodule

`default_nettype wire

// File: source/csr_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux (
    input  wire [csr_pkg::CSR_ADDR_W-1:0] raddr,
    input  wire csr_pkg::mode_view_t      mode,
    input  wire csr_pkg::int_view_t       intr,
    input  wire csr_pkg::timer_view_t     timer,
    input  wire csr_pkg::save_view_t      save,
    output logic [csr_pkg::XLEN-1:0]      rdata
);

    always_comb begin
        rdata = '0;
        case (raddr)
            csr_pkg::ADDR_CRMD: begin
                rdata = mode.crmd;
            end
            csr_pkg::ADDR_PRMD: begin
                rdata = mode.prmd;
            end
            csr_pkg::ADDR_ECFG: begin
                rdata = intr.ecfg;
            end
            csr_pkg::ADDR_ESTAT: begin
                // Codes from the mode group with pending bits below them
                rdata = mode.estat_code;
                rdata[csr_pkg::INT_W-1:0] = intr.is_bits;
            end
            csr_pkg::ADDR_ERA: begin
                rdata = mode.era;
            end
            csr_pkg::ADDR_EENTRY: begin
                rdata = mode.eentry;
            end
            csr_pkg::ADDR_SAVE0: begin
                rdata = save.word[0];
            end
            csr_pkg::ADDR_SAVE1: begin
                rdata = save.word[1];
            end
            csr_pkg::ADDR_SAVE2: begin
                rdata = save.word[2];
            end
            csr_pkg::ADDR_SAVE3: begin
                rdata = save.word[3];
            end
            csr_pkg::ADDR_TID: begin
                rdata = timer.tid;
            end
            csr_pkg::ADDR_TCFG: begin
                rdata = timer.tcfg;
            end
            csr_pkg::ADDR_TVAL: begin
                rdata = timer.tval;
            end
            // Write-only clear strobe
            csr_pkg::ADDR_TICLR: begin
                rdata = '0;
            end
            default: begin
                rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/csr_scratch_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_scratch_regs (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire csr_pkg::csr_wr_t wr,
    output csr_pkg::save_view_t   view
);

    logic [csr_pkg::SAVE_N-1:0][csr_pkg::XLEN-1:0] save;

    // SAVE0..3 sit at consecutive addresses
    always_ff @(posedge clk) begin
        if (!resetn) begin
            save <= '0;
        end else begin
            for (int i = 0; i < csr_pkg::SAVE_N; i++) begin
                if (csr_pkg::wr_hit(wr, csr_pkg::ADDR_SAVE0 + i[csr_pkg::CSR_ADDR_W-1:0])) begin
                    save[i] <= csr_pkg::mask_merge(save[i], wr);
                end
            end
        end
    end

    assign view.word = save;

endmodule

`default_nettype wire

// File: source/csr_timer.sv
`timescale 1ns/1ps
`default_nettype none

module csr_timer (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire csr_pkg::csr_wr_t wr,
    output csr_pkg::timer_view_t  view,
    output logic                  timer_fire,
    output logic                  tmr_clear
);

    logic en;
    logic periodic;
    logic [csr_pkg::XLEN-1:csr_pkg::TCFG_INITVAL_LSB] initval;
    logic [csr_pkg::XLEN-1:0] tid;
    logic [csr_pkg::XLEN-1:0] cnt;

    logic [csr_pkg::XLEN-1:0] tcfg_word;
    logic [csr_pkg::XLEN-1:0] tcfg_next;
    logic tcfg_we;
    logic load;

    always_comb begin
        tcfg_word = '0;
        tcfg_word[csr_pkg::TCFG_EN] = en;
        tcfg_word[csr_pkg::TCFG_PERIODIC] = periodic;
        tcfg_word[csr_pkg::XLEN-1:csr_pkg::TCFG_INITVAL_LSB] = initval;
    end

    assign tcfg_we   = csr_pkg::wr_hit(wr, csr_pkg::ADDR_TCFG);
    assign tcfg_next = csr_pkg::mask_merge(tcfg_word, wr);
    assign load      = tcfg_we && tcfg_next[csr_pkg::TCFG_EN];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            en       <= 1'b0;
            periodic <= 1'b0;
            initval  <= '0;
            tid      <= '0;
        end else begin
            if (tcfg_we) begin
                en       <= tcfg_next[csr_pkg::TCFG_EN];
                periodic <= tcfg_next[csr_pkg::TCFG_PERIODIC];
                initval  <= tcfg_next[csr_pkg::XLEN-1:csr_pkg::TCFG_INITVAL_LSB];
            end
            if (csr_pkg::wr_hit(wr, csr_pkg::ADDR_TID)) begin
                tid <= csr_pkg::mask_merge(tid, wr);
            end
        end
    end

    // Countdown parks at all ones in one-shot mode
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt <= csr_pkg::TIMER_IDLE;
        end else if (load) begin
            cnt <= {tcfg_next[csr_pkg::XLEN-1:csr_pkg::TCFG_INITVAL_LSB],
                    {csr_pkg::TCFG_INITVAL_LSB{1'b0}}};
        end else if (en && cnt != csr_pkg::TIMER_IDLE) begin
            if (cnt == '0 && periodic) begin
                cnt <= {initval, {csr_pkg::TCFG_INITVAL_LSB{1'b0}}};
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign timer_fire = en && (cnt == '0);
    assign tmr_clear  = csr_pkg::wr_hit(wr, csr_pkg::ADDR_TICLR) &&
                        wr.wmask[csr_pkg::TICLR_CLR] && wr.wdata[csr_pkg::TICLR_CLR];

    assign view.tcfg = tcfg_word;
    assign view.tval = cnt;
    assign view.tid  = tid;

    a_cnt_frozen_when_off: assert property (@(posedge clk) disable iff (!resetn)
        (!en && !load) |=> $stable(cnt));

endmodule

`default_nettype wire

// File: source/csr_int_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module csr_int_ctrl (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire csr_pkg::csr_wr_t wr,
    input  wire                   crmd_ie,
    input  wire                   timer_fire,
    input  wire                   tmr_clear,
    output csr_pkg::int_view_t    view,
    output logic                  has_int
);

    logic [csr_pkg::INT_W-1:0] lie;
    logic [csr_pkg::SW_INT_W-1:0] sw_is;
    logic timer_is;

    logic [csr_pkg::XLEN-1:0] ecfg_word;
    logic [csr_pkg::XLEN-1:0] ecfg_new;
    logic [csr_pkg::XLEN-1:0] sw_word;
    logic [csr_pkg::XLEN-1:0] sw_new;

    always_comb begin
        ecfg_word = '0;
        ecfg_word[csr_pkg::INT_W-1:0] = lie;
        sw_word = '0;
        sw_word[csr_pkg::SW_INT_W-1:0] = sw_is;
        view.is_bits = '0;
        view.is_bits[csr_pkg::SW_INT_W-1:0] = sw_is;
        view.is_bits[csr_pkg::TIMER_INT_BIT] = timer_is;
    end

    assign ecfg_new = csr_pkg::mask_merge(ecfg_word, wr);
    assign sw_new   = csr_pkg::mask_merge(sw_word, wr);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lie   <= '0;
            sw_is <= '0;
        end else begin
            if (csr_pkg::wr_hit(wr, csr_pkg::ADDR_ECFG)) begin
                lie <= ecfg_new[csr_pkg::INT_W-1:0];
            end
            if (csr_pkg::wr_hit(wr, csr_pkg::ADDR_ESTAT)) begin
                sw_is <= sw_new[csr_pkg::SW_INT_W-1:0];
            end
        end
    end

    // Timer pending bit where set beats clear
    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer_is <= 1'b0;
        end else if (timer_fire) begin
            timer_is <= 1'b1;
        end else if (tmr_clear) begin
            timer_is <= 1'b0;
        end
    end

    assign view.ecfg = ecfg_word;
    assign has_int   = (|(view.is_bits[csr_pkg::TIMER_INT_BIT:0] &
                          lie[csr_pkg::TIMER_INT_BIT:0])) && crmd_ie;

    // Hardware lines and IPI stay low
    a_is_unused_zero: assert property (@(posedge clk) disable iff (!resetn)
        view.is_bits[csr_pkg::TIMER_INT_BIT-1:csr_pkg::SW_INT_W] == '0 &&
        view.is_bits[csr_pkg::INT_W-1:csr_pkg::TIMER_INT_BIT+1] == '0);

endmodule

`default_nettype wire

// File: source/csr_mode_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_mode_regs (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire csr_pkg::csr_wr_t    wr,
    input  wire csr_pkg::exc_evt_t   evt,
    output csr_pkg::mode_view_t      view,
    output logic                     crmd_ie,
    output logic                     flush,
    output logic [csr_pkg::XLEN-1:0] flush_pc
);

    logic [csr_pkg::PLV_W-1:0] plv;
    logic ie;
    logic da;
    logic pg;
    logic [csr_pkg::DAT_W-1:0] datf;
    logic [csr_pkg::DAT_W-1:0] datm;
    logic [csr_pkg::PLV_W-1:0] pplv;
    logic pie;
    logic [csr_pkg::ECODE_W-1:0] ecode;
    logic [csr_pkg::ESUBCODE_W-1:0] esubcode;
    logic [csr_pkg::XLEN-1:0] era;
    logic [csr_pkg::XLEN-1:csr_pkg::EENTRY_VA_LSB] eentry_va;

    logic [csr_pkg::XLEN-1:0] crmd_word;
    logic [csr_pkg::XLEN-1:0] prmd_word;
    logic [csr_pkg::XLEN-1:0] estat_word;
    logic [csr_pkg::XLEN-1:0] eentry_word;
    logic [csr_pkg::XLEN-1:0] crmd_new;
    logic [csr_pkg::XLEN-1:0] prmd_new;
    logic [csr_pkg::XLEN-1:0] eentry_new;

    always_comb begin
        crmd_word = '0;
        crmd_word[csr_pkg::CRMD_PLV_LSB +: csr_pkg::PLV_W] = plv;
        crmd_word[csr_pkg::CRMD_IE] = ie;
        crmd_word[csr_pkg::CRMD_DA] = da;
        crmd_word[csr_pkg::CRMD_PG] = pg;
        crmd_word[csr_pkg::CRMD_DATF_LSB +: csr_pkg::DAT_W] = datf;
        crmd_word[csr_pkg::CRMD_DATM_LSB +: csr_pkg::DAT_W] = datm;
        prmd_word = '0;
        prmd_word[csr_pkg::PRMD_PPLV_LSB +: csr_pkg::PLV_W] = pplv;
        prmd_word[csr_pkg::PRMD_PIE] = pie;
        estat_word = '0;
        estat_word[csr_pkg::ESTAT_ECODE_LSB +: csr_pkg::ECODE_W] = ecode;
        estat_word[csr_pkg::ESTAT_ESUBCODE_LSB +: csr_pkg::ESUBCODE_W] = esubcode;
    end

    assign eentry_word = {eentry_va, {csr_pkg::EENTRY_VA_LSB{1'b0}}};
    assign crmd_new    = csr_pkg::mask_merge(crmd_word, wr);
    assign prmd_new    = csr_pkg::mask_merge(prmd_word, wr);
    assign eentry_new  = csr_pkg::mask_merge(eentry_word, wr);

    // Privilege level and global interrupt enable
    always_ff @(posedge clk) begin
        if (!resetn) begin
            plv <= '0;
            ie  <= 1'b0;
        end else if (evt.exc) begin
            plv <= '0;
            ie  <= 1'b0;
        end else if (evt.ertn) begin
            plv <= pplv;
            ie  <= pie;
        end else if (csr_pkg::wr_hit(wr, csr_pkg::ADDR_CRMD)) begin
            plv <= crmd_new[csr_pkg::CRMD_PLV_LSB +: csr_pkg::PLV_W];
            ie  <= crmd_new[csr_pkg::CRMD_IE];
        end
    end

    // Translation mode fields are written by software only
    always_ff @(posedge clk) begin
        if (!resetn) begin
            da   <= 1'b1;
            pg   <= 1'b0;
            datf <= '0;
            datm <= '0;
        end else if (csr_pkg::wr_hit(wr, csr_pkg::ADDR_CRMD)) begin
            da   <= crmd_new[csr_pkg::CRMD_DA];
            pg   <= crmd_new[csr_pkg::CRMD_PG];
            datf <= crmd_new[csr_pkg::CRMD_DATF_LSB +: csr_pkg::DAT_W];
            datm <= crmd_new[csr_pkg::CRMD_DATM_LSB +: csr_pkg::DAT_W];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pplv     <= '0;
            pie      <= 1'b0;
            era      <= '0;
            ecode    <= '0;
            esubcode <= '0;
        end else if (evt.exc) begin
            pplv     <= plv;
            pie      <= ie;
            era      <= evt.pc;
            ecode    <= evt.ecode;
            esubcode <= evt.esubcode;
        end else begin
            if (csr_pkg::wr_hit(wr, csr_pkg::ADDR_PRMD)) begin
                pplv <= prmd_new[csr_pkg::PRMD_PPLV_LSB +: csr_pkg::PLV_W];
                pie  <= prmd_new[csr_pkg::PRMD_PIE];
            end
            if (csr_pkg::wr_hit(wr, csr_pkg::ADDR_ERA)) begin
                era <= csr_pkg::mask_merge(era, wr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry_va <= '0;
        end else if (csr_pkg::wr_hit(wr, csr_pkg::ADDR_EENTRY)) begin
            eentry_va <= eentry_new[csr_pkg::XLEN-1:csr_pkg::EENTRY_VA_LSB];
        end
    end

    assign view.crmd       = crmd_word;
    assign view.prmd       = prmd_word;
    assign view.estat_code = estat_word;
    assign view.era        = era;
    assign view.eentry     = eentry_word;
    assign crmd_ie         = ie;

    // Entry wins over refetch, which wins over return
    assign flush    = evt.exc | evt.ertn | evt.refetch;
    assign flush_pc = evt.exc     ? eentry_word :
                      evt.refetch ? evt.pc + csr_pkg::INSN_BYTES :
                                    era;

    a_no_exc_with_ertn: assert property (@(posedge clk) disable iff (!resetn)
        !(evt.exc && evt.ertn));

endmodule

`default_nettype wire

// File: source/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // Data path and field widths
    localparam int XLEN          = 32;
    localparam int CSR_ADDR_W    = 14;
    localparam int ECODE_W       = 6;
    localparam int ESUBCODE_W    = 9;
    localparam int INT_W         = 13;
    localparam int TIMER_INT_BIT = 11;
    localparam int SW_INT_W      = 2;
    localparam int SAVE_N        = 4;

    localparam logic [XLEN-1:0] TIMER_IDLE = '1;
    localparam logic [XLEN-1:0] INSN_BYTES = 32'd4;

    // Register addresses
    localparam logic [CSR_ADDR_W-1:0] ADDR_CRMD   = 14'h000;
    localparam logic [CSR_ADDR_W-1:0] ADDR_PRMD   = 14'h001;
    localparam logic [CSR_ADDR_W-1:0] ADDR_ECFG   = 14'h004;
    localparam logic [CSR_ADDR_W-1:0] ADDR_ESTAT  = 14'h005;
    localparam logic [CSR_ADDR_W-1:0] ADDR_ERA    = 14'h006;
    localparam logic [CSR_ADDR_W-1:0] ADDR_EENTRY = 14'h00c;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SAVE0  = 14'h030;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SAVE1  = 14'h031;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SAVE2  = 14'h032;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SAVE3  = 14'h033;
    localparam logic [CSR_ADDR_W-1:0] ADDR_TID    = 14'h040;
    localparam logic [CSR_ADDR_W-1:0] ADDR_TCFG   = 14'h041;
    localparam logic [CSR_ADDR_W-1:0] ADDR_TVAL   = 14'h042;
    localparam logic [CSR_ADDR_W-1:0] ADDR_TICLR  = 14'h044;

    // Field positions
    localparam int PLV_W              = 2;
    localparam int DAT_W              = 2;
    localparam int CRMD_PLV_LSB       = 0;
    localparam int CRMD_IE            = 2;
    localparam int CRMD_DA            = 3;
    localparam int CRMD_PG            = 4;
    localparam int CRMD_DATF_LSB      = 5;
    localparam int CRMD_DATM_LSB      = 7;
    localparam int PRMD_PPLV_LSB      = 0;
    localparam int PRMD_PIE           = 2;
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;
    localparam int TCFG_EN            = 0;
    localparam int TCFG_PERIODIC      = 1;
    localparam int TCFG_INITVAL_LSB   = 2;
    localparam int EENTRY_VA_LSB      = 6;
    localparam int TICLR_CLR          = 0;

    typedef struct packed {
        logic                  we;
        logic [CSR_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wmask;
        logic [XLEN-1:0]       wdata;
    } csr_wr_t;

    typedef struct packed {
        logic                  exc;
        logic [ECODE_W-1:0]    ecode;
        logic [ESUBCODE_W-1:0] esubcode;
        logic [XLEN-1:0]       pc;
        logic                  ertn;
        logic                  refetch;
    } exc_evt_t;

    // ESTAT interrupt bits are zero in estat_code
    typedef struct packed {
        logic [XLEN-1:0] crmd;
        logic [XLEN-1:0] prmd;
        logic [XLEN-1:0] estat_code;
        logic [XLEN-1:0] era;
        logic [XLEN-1:0] eentry;
    } mode_view_t;

    typedef struct packed {
        logic [XLEN-1:0]  ecfg;
        logic [INT_W-1:0] is_bits;
    } int_view_t;

    typedef struct packed {
        logic [XLEN-1:0] tcfg;
        logic [XLEN-1:0] tval;
        logic [XLEN-1:0] tid;
    } timer_view_t;

    typedef struct packed {
        logic [SAVE_N-1:0][XLEN-1:0] word;
    } save_view_t;

    function automatic logic wr_hit(input csr_wr_t w, input logic [CSR_ADDR_W-1:0] addr);
        return w.we && (w.waddr == addr);
    endfunction

    // New bits under the mask, old bits elsewhere
    function automatic logic [XLEN-1:0] mask_merge(input logic [XLEN-1:0] old_word,
                                                   input csr_wr_t w);
        return (w.wmask & w.wdata) | (~w.wmask & old_word);
    endfunction

endpackage

`default_nettype wire
